// File: logic/frame_rx_pkg.sv
package frame_rx_pkg;

    // Frame delimiters and special command codes
    localparam logic [7:0] SOF_HOST_TO_DEVICE = 8'hA5;   // Host to device start of frame
    localparam logic [7:0] CMD_RESET          = 8'hFF;   // Soft reset request, no addr/data

    // Write data buffer sizing
    // 16 beats max (4-bit length field) of up to 4 bytes each
    localparam int MAX_DATA_BYTES = 64;
    localparam int DATA_IDX_W     = $clog2(MAX_DATA_BYTES);       // 6 bits
    localparam int DATA_CNT_W     = $clog2(MAX_DATA_BYTES + 1);   // 7 bits, holds 0..64

    // Status codes returned with each finished frame
    typedef enum logic [7:0] {
        STATUS_OK      = 8'h00,
        STATUS_CRC_ERR = 8'h01,   // Received CRC differs from running CRC
        STATUS_CMD_INV = 8'h02    // Reserved size field in command
    } status_t;

    // Command byte bits 5:4, bytes per beat
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,   // 1 byte
        SIZE_HALF = 2'b01,   // 2 bytes
        SIZE_WORD = 2'b10,   // 4 bytes
        SIZE_RSVD = 2'b11    // Not supported, flagged as invalid command
    } size_t;

    // Command byte layout
    //   [7]   read when set, write when clear
    //   [6]   address increment, passed through untouched
    //   [5:4] size_t
    //   [3:0] beat count minus one

endpackage

// File: logic/crc8_engine.sv
`timescale 1ns/100ps

module crc8_engine #(
    parameter logic [7:0] CRC_POLY = 8'h07   // Normal form, x^8 term implied
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       crc_clear,    // Start of a new frame
    input  logic       crc_enable,   // Fold byte_in into the running CRC
    input  logic [7:0] byte_in,
    output logic       crc_match     // Live byte equals running CRC
);

    logic [7:0] crc_q;   // Running CRC over cmd, addr and data bytes

    // One byte through the LFSR, MSB first, no reflection
    function automatic logic [7:0] crc_step(input logic [7:0] crc_in, input logic [7:0] data);
        logic [7:0] c;
        logic       fb;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ data[i];          // Feedback from top bit and incoming bit
            c  = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= 8'h00;
        end else if (crc_clear) begin
            crc_q <= 8'h00;                        // Init value zero, no final XOR
        end else if (crc_enable) begin
            crc_q <= crc_step(crc_q, byte_in);
        end
    end

    // Only meaningful while the CRC byte sits at the FIFO head
    assign crc_match = (byte_in == crc_q);

endmodule

// File: logic/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder
    import frame_rx_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_load,        // Command byte is being read
    input  logic [7:0]            byte_in,
    output logic                  load_is_reset,   // Live byte is the reset command
    output logic [7:0]            cmd,
    output logic                  is_reset,
    output logic                  cmd_valid,
    output logic [DATA_CNT_W-1:0] expected_bytes   // Write data bytes to follow address
);

    logic                  rw_bit;
    size_t                 size_f;
    logic [DATA_CNT_W-1:0] beats;      // Length field plus one
    logic [DATA_CNT_W-1:0] bytes_d;    // Decoded byte count for the live byte
    logic                  valid_d;

    assign rw_bit        = byte_in[7];
    assign size_f        = size_t'(byte_in[5:4]);
    assign beats         = DATA_CNT_W'(byte_in[3:0]) + DATA_CNT_W'(1);
    assign load_is_reset = (byte_in == CMD_RESET);

    always_comb begin
        bytes_d = '0;   // Reads, reset and reserved size carry no data
        if (!rw_bit && !load_is_reset) begin
            case (size_f)
                SIZE_BYTE: bytes_d = beats;
                SIZE_HALF: bytes_d = beats << 1;
                SIZE_WORD: bytes_d = beats << 2;   // Max 16 * 4 = 64
                default:   bytes_d = '0;
            endcase
        end
    end

    assign valid_d = load_is_reset || (size_f != SIZE_RSVD);

    // Command byte itself is payload, held for the consumer
    always_ff @(posedge clk) begin
        if (cmd_load) begin
            cmd <= byte_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            is_reset       <= 1'b0;
            cmd_valid      <= 1'b0;
            expected_bytes <= '0;
        end else if (cmd_load) begin
            is_reset       <= load_is_reset;
            cmd_valid      <= valid_d;
            expected_bytes <= bytes_d;
        end
    end

endmodule

// File: logic/payload_store.sv
`timescale 1ns/100ps

module payload_store
    import frame_rx_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_start,      // SOF accepted, restart byte count
    input  logic                  addr_load,        // Address byte being read
    input  logic                  data_load,        // Data byte being read
    input  logic [7:0]            byte_in,
    input  logic [DATA_CNT_W-1:0] expected_bytes,
    input  logic [DATA_IDX_W-1:0] data_rd_idx,
    output logic [31:0]           addr,
    output logic [DATA_CNT_W-1:0] data_count,
    output logic                  data_last,        // This data byte completes the frame
    output logic [7:0]            data_rd_byte
);

    logic [31:0]           addr_q;
    logic [7:0]            data_mem [MAX_DATA_BYTES];
    logic [DATA_CNT_W-1:0] count_q;

    // Little endian, each byte enters at the top and slides down
    // After four loads the first byte sits in [7:0]
    always_ff @(posedge clk) begin
        if (addr_load) begin
            addr_q <= {byte_in, addr_q[31:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (data_load) begin
            data_mem[count_q[DATA_IDX_W-1:0]] <= byte_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (frame_start) begin
            count_q <= '0;
        end else if (data_load) begin
            count_q <= count_q + DATA_CNT_W'(1);
        end
    end

    assign data_last    = ((count_q + DATA_CNT_W'(1)) == expected_bytes);
    assign addr         = addr_q;
    assign data_count   = count_q;
    assign data_rd_byte = data_mem[data_rd_idx];   // Async read port for the consumer

    // Controller must stop loading once the decoded length is reached
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        data_load |-> (count_q != DATA_CNT_W'(MAX_DATA_BYTES))
    ) else $error("Data buffer overflow at %0t", $time);

endmodule

// File: logic/parse_ctrl.sv
`timescale 1ns/100ps

module parse_ctrl
    import frame_rx_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            byte_in,          // FIFO head, checked for SOF
    input  logic                  rx_fifo_empty,
    input  logic                  frame_consumed,
    input  logic                  load_is_reset,
    input  logic                  is_reset,
    input  logic                  cmd_valid,
    input  logic [DATA_CNT_W-1:0] expected_bytes,
    input  logic                  data_last,
    input  logic                  crc_match,
    output logic                  rx_fifo_rd_en,
    output logic                  crc_clear,
    output logic                  crc_enable,
    output logic                  cmd_load,
    output logic                  addr_load,
    output logic                  data_load,
    output logic                  frame_start,
    output logic                  frame_valid,
    output logic                  frame_error,
    output status_t               error_status,
    output logic                  parser_busy,
    output logic                  soft_reset_request
);

    typedef enum logic [2:0] {
        ST_IDLE,   // Hunt for SOF, drop anything else
        ST_CMD,
        ST_ADDR,   // Four bytes, counted by addr_cnt
        ST_DATA,
        ST_CRC,
        ST_HOLD    // Frame result presented, wait for consumer
    } state_t;

    state_t     state, state_next;
    logic [1:0] addr_cnt;
    status_t    status_q;
    logic       soft_rst_q;
    logic       rd;             // A byte is consumed this cycle
    logic       crc_rd;         // CRC byte consumed this cycle
    logic       reset_ok;       // Reset frame with good CRC

    // Every state but hold pulls bytes when available
    assign rd            = (state != ST_HOLD) && !rx_fifo_empty;
    assign rx_fifo_rd_en = rd;
    assign crc_rd        = rd && (state == ST_CRC);
    assign reset_ok      = is_reset && crc_match;

    always_comb begin
        state_next  = state;
        crc_clear   = 1'b0;
        crc_enable  = 1'b0;
        cmd_load    = 1'b0;
        addr_load   = 1'b0;
        data_load   = 1'b0;
        frame_start = 1'b0;
        case (state)
            ST_IDLE: begin
                if (rd && (byte_in == SOF_HOST_TO_DEVICE)) begin
                    frame_start = 1'b1;
                    crc_clear   = 1'b1;   // SOF itself is not covered
                    state_next  = ST_CMD;
                end
            end
            ST_CMD: begin
                if (rd) begin
                    crc_enable = 1'b1;
                    cmd_load   = 1'b1;
                    state_next = load_is_reset ? ST_CRC : ST_ADDR;   // Reset has no addr/data
                end
            end
            ST_ADDR: begin
                if (rd) begin
                    crc_enable = 1'b1;
                    addr_load  = 1'b1;
                    if (addr_cnt == 2'd3) begin
                        state_next = (expected_bytes != '0) ? ST_DATA : ST_CRC;
                    end
                end
            end
            ST_DATA: begin
                if (rd) begin
                    crc_enable = 1'b1;
                    data_load  = 1'b1;
                    if (data_last) begin
                        state_next = ST_CRC;
                    end
                end
            end
            ST_CRC: begin
                if (rd) begin
                    state_next = reset_ok ? ST_IDLE : ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (frame_consumed) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            addr_cnt   <= 2'd0;
            status_q   <= STATUS_OK;
            soft_rst_q <= 1'b0;
        end else begin
            state      <= state_next;
            soft_rst_q <= crc_rd && reset_ok;                  // Single cycle pulse
            if (cmd_load) begin
                addr_cnt <= 2'd0;
            end else if (addr_load) begin
                addr_cnt <= addr_cnt + 2'd1;
            end
            // Status priority: bad command first, then CRC
            if (crc_rd) begin
                if (!cmd_valid) begin
                    status_q <= STATUS_CMD_INV;
                end else if (!crc_match) begin
                    status_q <= STATUS_CRC_ERR;
                end else begin
                    status_q <= STATUS_OK;
                end
            end
        end
    end

    assign frame_valid        = (state == ST_HOLD) && (status_q == STATUS_OK);
    assign frame_error        = (state == ST_HOLD) && (status_q != STATUS_OK);
    assign error_status       = status_q;
    assign parser_busy        = (state != ST_IDLE);
    assign soft_reset_request = soft_rst_q;

    a_rd_not_empty: assert property (
        @(posedge clk) disable iff (rst) rx_fifo_rd_en |-> !rx_fifo_empty
    ) else $error("Read from empty RX FIFO at %0t", $time);

    a_valid_err_excl: assert property (
        @(posedge clk) disable iff (rst) !(frame_valid && frame_error)
    ) else $error("frame_valid and frame_error together at %0t", $time);

    a_soft_rst_pulse: assert property (
        @(posedge clk) disable iff (rst) soft_reset_request |=> !soft_reset_request
    ) else $error("soft_reset_request longer than one cycle at %0t", $time);

endmodule

// File: logic/frame_rx_top.sv
`timescale 1ns/100ps

module frame_rx_top
    import frame_rx_pkg::*;
#(
    parameter logic [7:0] CRC_POLY = 8'h07
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            rx_fifo_data,     // FWFT head, valid while not empty
    input  logic                  rx_fifo_empty,
    input  logic                  frame_consumed,
    input  logic [DATA_IDX_W-1:0] data_rd_idx,
    output logic                  rx_fifo_rd_en,
    output logic [7:0]            cmd,
    output logic [31:0]           addr,
    output logic [DATA_CNT_W-1:0] data_count,
    output logic [7:0]            data_rd_byte,
    output logic                  frame_valid,
    output logic                  frame_error,
    output status_t               error_status,
    output logic                  parser_busy,
    output logic                  soft_reset_request
);

    // Controller strobes, all qualified by a byte read
    logic crc_clear, crc_enable, cmd_load, addr_load, data_load, frame_start;
    // Datapath status back to the controller
    logic                  load_is_reset, is_reset, cmd_valid, data_last, crc_match;
    logic [DATA_CNT_W-1:0] expected_bytes;

    parse_ctrl u_ctrl (
        .clk, .rst,
        .byte_in (rx_fifo_data),
        .rx_fifo_empty, .frame_consumed,
        .load_is_reset, .is_reset, .cmd_valid, .expected_bytes, .data_last, .crc_match,
        .rx_fifo_rd_en, .crc_clear, .crc_enable, .cmd_load, .addr_load, .data_load,
        .frame_start, .frame_valid, .frame_error, .error_status, .parser_busy,
        .soft_reset_request
    );

    crc8_engine #(
        .CRC_POLY (CRC_POLY)
    ) u_crc (
        .clk, .rst, .crc_clear, .crc_enable,
        .byte_in (rx_fifo_data),
        .crc_match
    );

    cmd_decoder u_cmd (
        .clk, .rst, .cmd_load,
        .byte_in (rx_fifo_data),
        .load_is_reset, .cmd, .is_reset, .cmd_valid, .expected_bytes
    );

    payload_store u_store (
        .clk, .rst, .frame_start, .addr_load, .data_load,
        .byte_in (rx_fifo_data),
        .expected_bytes, .data_rd_idx,
        .addr, .data_count, .data_last, .data_rd_byte
    );

endmodule

// File: tb/frame_rx_tb.sv
`timescale 1ns/100ps

module frame_rx_tb
    import frame_rx_pkg::*;
();

    localparam logic [7:0] CRC_POLY = 8'h07;
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_ROWS    = 13;
    localparam int FRAME_MAX   = 70;                    // Rough upper bound on frame length
    localparam int MAX_GAP     = FRAME_MAX;             // At most one empty cycle per byte
    localparam int MAX_DELAY   = MAX_DATA_BYTES + 9;    // Readback plus consumer delay
    localparam int WATCHDOG_NS = NUM_ROWS * (FRAME_MAX + MAX_GAP + MAX_DELAY) * CLK_PERIOD * 2;
    localparam int KIND_VALID  = 0;
    localparam int KIND_ERROR  = 1;
    localparam int KIND_RESET  = 2;

    typedef struct packed {
        logic [7:0]  cmd;       // Length nibble 0 on a write means random length
        logic [31:0] addr;
        logic        corrupt;   // Flip bit 0 of the CRC byte
        logic [1:0]  junk;      // Non-SOF bytes ahead of the frame
        logic        gap;       // Random empty cycles in the FIFO
    } row_t;

    localparam row_t TABLE [NUM_ROWS] = '{
        '{8'h00, 32'h1234_5678, 1'b0, 2'd0, 1'b0},   // Byte writes of random length
        '{8'h1F, 32'hDEAD_BEEF, 1'b0, 2'd2, 1'b0},   // 16 halfwords
        '{8'h2F, 32'h0000_1000, 1'b0, 2'd0, 1'b1},   // Full 64 byte buffer
        '{8'h20, 32'hCAFE_0004, 1'b0, 2'd1, 1'b1},
        '{8'h83, 32'h4000_0000, 1'b0, 2'd0, 1'b0},   // Read with no data
        '{8'h05, 32'h8000_0010, 1'b1, 2'd0, 1'b0},   // Bad CRC
        '{8'h31, 32'h0BAD_0001, 1'b0, 2'd0, 1'b0},   // Reserved size
        '{8'hFF, 32'h0000_0000, 1'b0, 2'd0, 1'b0},   // Soft reset
        '{8'hFF, 32'h0000_0000, 1'b1, 2'd1, 1'b0},   // Soft reset with bad CRC
        '{8'h10, 32'hFFFF_FFFC, 1'b0, 2'd3, 1'b1},
        '{8'hC7, 32'h0000_0000, 1'b0, 2'd2, 1'b1},
        '{8'h27, 32'h0102_0304, 1'b1, 2'd0, 1'b1},
        '{8'h00, 32'h55AA_55AA, 1'b0, 2'd0, 1'b1}
    };

    logic                  clk;
    logic                  rst;
    logic [7:0]            rx_fifo_data;
    logic                  rx_fifo_empty;
    logic                  frame_consumed;
    logic [DATA_IDX_W-1:0] data_rd_idx;
    logic                  rx_fifo_rd_en;
    logic [7:0]            cmd;
    logic [31:0]           addr;
    logic [DATA_CNT_W-1:0] data_count;
    logic [7:0]            data_rd_byte;
    logic                  frame_valid;
    logic                  frame_error;
    status_t               error_status;
    logic                  parser_busy;
    logic                  soft_reset_request;

    logic [7:0]  fifo_q [$];                        // Bytes waiting in the RX FIFO model
    logic [7:0]  popped;
    logic        gap_en;
    logic        gap_now;
    logic [31:0] gap_rnd;                           // Own LCG stream for the FIFO
    logic [31:0] rnd;                               // Stream for data, lengths, delays
    logic [7:0]  frame_bytes [NUM_ROWS][FRAME_MAX + 8];
    int          frame_len   [NUM_ROWS];
    int          data_ofs    [NUM_ROWS];            // Index of first data byte
    int          exp_n       [NUM_ROWS];
    int          exp_kind    [NUM_ROWS];
    logic [7:0]  exp_cmd     [NUM_ROWS];
    status_t     exp_status  [NUM_ROWS];
    int          err_cnt;
    int          tests_failed;

    frame_rx_top #(.CRC_POLY(CRC_POLY)) DUT (
        .clk, .rst, .rx_fifo_data, .rx_fifo_empty, .frame_consumed, .data_rd_idx,
        .rx_fifo_rd_en, .cmd, .addr, .data_count, .data_rd_byte, .frame_valid,
        .frame_error, .error_status, .parser_busy, .soft_reset_request
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Byte-wise CRC taken MSB first from zero with no final XOR
    function automatic logic [7:0] crc_update(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] r;
        r = crc ^ b;
        repeat (8) begin
            r = r[7] ? ((r << 1) ^ CRC_POLY) : (r << 1);
        end
        return r;
    endfunction

    // Write data bytes announced by a command byte
    function automatic int expected_len(input logic [7:0] c);
        if (c[7] || c == CMD_RESET || c[5:4] == 2'b11) begin
            return 0;
        end
        return (int'(c[3:0]) + 1) * (1 << c[5:4]);
    endfunction

    task automatic draw(output logic [31:0] v);
        rnd = lcg_next(rnd);
        v   = rnd >> 8;                             // Low LCG bits are weak
    endtask

    task automatic add_byte(input int r, input logic [7:0] b, inout logic [7:0] crc,
                            input bit covered);
        frame_bytes[r][frame_len[r]] = b;
        frame_len[r] = frame_len[r] + 1;
        if (covered) begin
            crc = crc_update(crc, b);
        end
    endtask

    task automatic build_frame(input int r);
        logic [7:0]  c;
        logic [7:0]  b;
        logic [7:0]  crc;
        logic [31:0] v;
        c = TABLE[r].cmd;
        crc = 8'h00;
        frame_len[r] = 0;
        if (!c[7] && c[5:4] != 2'b11 && c[3:0] == 4'h0) begin
            draw(v);
            c[3:0] = v[3:0];
        end
        for (int j = 0; j < TABLE[r].junk; j++) begin
            draw(v);
            b = (v[7:0] == SOF_HOST_TO_DEVICE) ? 8'h00 : v[7:0];   // Junk never looks like SOF
            add_byte(r, b, crc, 1'b0);
        end
        add_byte(r, SOF_HOST_TO_DEVICE, crc, 1'b0);
        add_byte(r, c, crc, 1'b1);
        if (c != CMD_RESET) begin
            for (int j = 0; j < 4; j++) begin
                add_byte(r, TABLE[r].addr[8*j +: 8], crc, 1'b1);   // LSB first
            end
        end
        data_ofs[r] = frame_len[r];
        exp_n[r]    = expected_len(c);
        for (int j = 0; j < exp_n[r]; j++) begin
            draw(v);
            add_byte(r, v[7:0], crc, 1'b1);
        end
        add_byte(r, TABLE[r].corrupt ? (crc ^ 8'h01) : crc, crc, 1'b0);
        exp_cmd[r] = c;
        // Bad command outranks bad CRC
        if (c == CMD_RESET && !TABLE[r].corrupt) begin
            exp_kind[r]   = KIND_RESET;
            exp_status[r] = STATUS_OK;
        end else if (c != CMD_RESET && c[5:4] == 2'b11) begin
            exp_kind[r]   = KIND_ERROR;
            exp_status[r] = STATUS_CMD_INV;
        end else if (TABLE[r].corrupt) begin
            exp_kind[r]   = KIND_ERROR;
            exp_status[r] = STATUS_CRC_ERR;
        end else begin
            exp_kind[r]   = KIND_VALID;
            exp_status[r] = STATUS_OK;
        end
    endtask

    task automatic push_frame(input int r);
        for (int j = 0; j < frame_len[r]; j++) begin
            fifo_q.push_back(frame_bytes[r][j]);
        end
    endtask

    task automatic check(input bit ok, input string msg);
        assert (ok) else begin
            $display("Fail at %0t ns: %s", $time, msg);
            err_cnt++;
        end
    endtask

    task automatic wait_result();
        do begin
            @(posedge clk);
            #2;                                     // Sample mid cycle
        end while (!(frame_valid || frame_error || soft_reset_request));
    endtask

    task automatic consume_frame();
        @(posedge clk);
        #1 frame_consumed = 1'b1;
        @(posedge clk);
        #1 frame_consumed = 1'b0;
    endtask

    // FWFT FIFO model pops on the edge and shows the new head 1 ns later
    always @(posedge clk) begin
        if (rx_fifo_rd_en && fifo_q.size() != 0) begin
            popped = fifo_q.pop_front();
        end
        #1;
        gap_rnd = lcg_next(gap_rnd);
        gap_now = gap_en && !gap_now && gap_rnd[20];   // Never two empty cycles in a row
        rx_fifo_empty = (fifo_q.size() == 0) || gap_now;
        rx_fifo_data  = (fifo_q.size() != 0) ? fifo_q[0] : 8'h00;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the DUT gave no frame result within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int          hold;
        int          errs_before;
        logic [31:0] v;
        logic [7:0]  held_cmd;
        logic [31:0] held_addr;
        status_t     held_status;
        clk = 1'b0;
        rst = 1'b1;
        rx_fifo_data   = 8'h00;
        rx_fifo_empty  = 1'b1;
        frame_consumed = 1'b0;
        data_rd_idx    = '0;
        gap_en  = 1'b0;
        gap_now = 1'b0;
        rnd     = 32'd50125;
        gap_rnd = lcg_next(32'd50125);
        err_cnt = 0;
        tests_failed = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_frame(r);
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        push_frame(0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            errs_before = err_cnt;
            gap_en = TABLE[r].gap;
            wait_result();
            if (exp_kind[r] == KIND_RESET) begin
                check(!frame_valid && !frame_error, "frame result on a good reset frame");
                check(!parser_busy, "parser_busy high during soft reset pulse");
                @(posedge clk);
                #2;
                check(!soft_reset_request, "soft_reset_request longer than one cycle");
                check(!frame_valid && !frame_error, "frame result after soft reset");
                if (frame_valid || frame_error) begin
                    consume_frame();
                end
                if (r + 1 < NUM_ROWS) begin
                    push_frame(r + 1);
                end
            end else begin
                check(!soft_reset_request, "unexpected soft_reset_request");
                check(frame_valid == (exp_kind[r] == KIND_VALID),
                      $sformatf("frame_valid %0b wrong", frame_valid));
                check(frame_error == (exp_kind[r] == KIND_ERROR),
                      $sformatf("frame_error %0b wrong", frame_error));
                check(error_status == exp_status[r], $sformatf("status %02h expected %02h",
                      error_status, exp_status[r]));
                check(cmd == exp_cmd[r], $sformatf("cmd %02h expected %02h", cmd, exp_cmd[r]));
                if (exp_cmd[r] != CMD_RESET) begin
                    check(addr == TABLE[r].addr, $sformatf("addr %08h expected %08h",
                          addr, TABLE[r].addr));
                end
                check(data_count == exp_n[r], $sformatf("data_count %0d expected %0d",
                      data_count, exp_n[r]));
                held_cmd    = cmd;
                held_addr   = addr;
                held_status = error_status;
                draw(v);
                hold = exp_n[r] + int'(v % 8) + 2;   // At least two cycles with bytes queued
                for (int c = 0; c < hold; c++) begin
                    @(posedge clk);
                    #1 data_rd_idx = DATA_IDX_W'(c);
                    #1;
                    check(!rx_fifo_rd_en, "rx_fifo_rd_en high while frame held");
                    check(frame_valid || frame_error, "frame dropped before consumed");
                    check(cmd == held_cmd && addr == held_addr && error_status == held_status,
                          "held frame changed before consumed");
                    if (c < exp_n[r]) begin
                        check(data_rd_byte == frame_bytes[r][data_ofs[r] + c],
                              $sformatf("data[%0d] %02h expected %02h", c, data_rd_byte,
                              frame_bytes[r][data_ofs[r] + c]));
                    end
                    if (c == 0 && r + 1 < NUM_ROWS) begin
                        push_frame(r + 1);     // Next frame waits behind the held one
                    end
                end
                consume_frame();
            end
            if (err_cnt == errs_before) begin
                $display("Test %0d cmd %02h: ok", r, exp_cmd[r]);
            end else begin
                $display("Test %0d cmd %02h: FAILED", r, exp_cmd[r]);
                tests_failed++;
            end
        end
        $display("Tests run %0d, failed %0d, failed checks %0d", NUM_ROWS, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: frame_rx.f
logic/frame_rx_pkg.sv
logic/crc8_engine.sv
logic/cmd_decoder.sv
logic/payload_store.sv
logic/parse_ctrl.sv
logic/frame_rx_top.sv
tb/frame_rx_tb.sv

// File: Bender.yml
package:
  name: frame_rx

sources:
  - logic/frame_rx_pkg.sv
  - logic/crc8_engine.sv
  - logic/cmd_decoder.sv
  - logic/payload_store.sv
  - logic/parse_ctrl.sv
  - logic/frame_rx_top.sv
  - target: test
    files:
      - tb/frame_rx_tb.sv
